// ==== hw/vid_bus_pkg.sv ====
// Video output bus definitions
// Avalon-MM widths, the register map and the register field layouts
`default_nettype none

package vid_bus_pkg;

  typedef logic [7:0]  bus_addr_t;
  typedef logic [15:0] bus_data_t;

  // Registers served by the control block itself
  localparam bus_addr_t REG_CTRL       = 8'd0;
  localparam bus_addr_t REG_STATUS     = 8'd1;
  localparam bus_addr_t REG_IRQ        = 8'd2;
  localparam bus_addr_t REG_USEDW      = 8'd3;
  localparam bus_addr_t REG_MODE_MATCH = 8'd4;
  localparam bus_addr_t SIDE_ADDR_LAST = 8'd4;

  // Mode bank layout, field address = MODE_BASE + mode * MODE_STRIDE + field
  localparam bus_addr_t MODE_BASE   = 8'h10;
  localparam bus_addr_t MODE_STRIDE = 8'd8;

  localparam bus_addr_t F_H_ACTIVE = 8'd0;
  localparam bus_addr_t F_H_TOTAL  = 8'd1;
  localparam bus_addr_t F_V_ACTIVE = 8'd2;
  localparam bus_addr_t F_V_TOTAL  = 8'd3;
  localparam bus_addr_t F_VALID    = 8'd4;

  // Bit 0 enable, bits 2:1 irq enables, bits 4:3 genlock enables
  typedef struct packed {
    logic [1:0] genlock_enable;
    logic [1:0] irq_enable;
    logic       enable;
  } ctrl_reg_t;

  typedef struct packed {
    logic      valid;
    bus_addr_t addr;
    bus_data_t data;
  } mode_wr_t;

endpackage

`default_nettype wire

// ==== hw/vid_video_pkg.sv ====
// Video datapath definitions
// Pixel and timing types, mode bank and FIFO sizes, raster output bundle
`default_nettype none

package vid_video_pkg;

  typedef logic [23:0] pixel_t;
  typedef logic [11:0] tcount_t;

  localparam int NUM_MODES = 2;
  typedef logic [NUM_MODES-1:0] mode_mask_t;

  typedef struct packed {
    tcount_t h_active;
    tcount_t h_total;
    tcount_t v_active;
    tcount_t v_total;
  } mode_timing_t;

  localparam int FIFO_DEPTH_LOG2 = 4;
  localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
  typedef logic [FIFO_DEPTH_LOG2:0] usedw_t;

  // Length of the hsync pulse at the start of each line
  localparam tcount_t HSYNC_CYCLES = 12'd8;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_FRAME,
    RUN
  } gen_state_t;

  typedef struct packed {
    logic   de;
    logic   hsync;
    logic   vsync;
    pixel_t pixel;
  } vid_out_t;

endpackage

`default_nettype wire

// ==== hw/vid_out_control.sv ====
// Video output control block
// Avalon-MM register file with control, status, interrupts and mode bank access
`timescale 1ns/100ps
`default_nettype none

module vid_out_control
  import vid_bus_pkg::*;
  import vid_video_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  bus_addr_t  av_address,
  input  logic       av_read,
  input  logic       av_write,
  input  bus_data_t  av_writedata,
  output bus_data_t  av_readdata,
  output logic       av_waitrequest,
  output mode_wr_t   mode_wr,
  input  logic       wr_ack,
  input  logic       mode_change,
  input  mode_mask_t mode_match,
  input  usedw_t     usedw,
  input  logic       underflow_sticky,
  input  logic       enable_resync,
  input  logic       genlocked,
  output ctrl_reg_t  ctrl,
  output logic       clear_underflow,
  output logic       write_trigger_ack,
  output logic       irq
);

  logic       side_addr;
  logic       side_wr;
  logic       status_clear_wr;
  logic       clear_req;
  logic       prev_genlocked;
  logic [2:1] irq_pend;
  mode_mask_t mode_match_q;
  bus_data_t  read_mux;

  assign side_addr       = av_address <= SIDE_ADDR_LAST;
  assign side_wr         = av_write && side_addr;
  assign status_clear_wr = side_wr && (av_address == REG_STATUS) && av_writedata[2];

  // Anything above the side range goes to the mode bank and waits for its ack
  assign mode_wr.valid  = av_write && !side_addr;
  assign mode_wr.addr   = av_address;
  assign mode_wr.data   = av_writedata;
  assign av_waitrequest = mode_wr.valid && !wr_ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl              <= '0;
      mode_match_q      <= '0;
      write_trigger_ack <= 1'b0;
      prev_genlocked    <= 1'b0;
    end else begin
      if (side_wr && (av_address == REG_CTRL)) begin
        ctrl <= ctrl_reg_t'(av_writedata[4:0]);
      end
      if (mode_change) begin
        mode_match_q <= mode_match;
      end
      write_trigger_ack <= wr_ack;
      prev_genlocked    <= genlocked;
    end
  end

  // Sticky pending bits, a new event wins over a clear in the same cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      irq_pend <= '0;
    end else begin
      if (mode_change && ctrl.irq_enable[0]) begin
        irq_pend[1] <= 1'b1;
      end else if (side_wr && (av_address == REG_IRQ) && av_writedata[1]) begin
        irq_pend[1] <= 1'b0;
      end
      if ((genlocked != prev_genlocked) && ctrl.irq_enable[1]) begin
        irq_pend[2] <= 1'b1;
      end else if (side_wr && (av_address == REG_IRQ) && av_writedata[2]) begin
        irq_pend[2] <= 1'b0;
      end
    end
  end

  assign irq = (irq_pend[1] && ctrl.irq_enable[0]) || (irq_pend[2] && ctrl.irq_enable[1]);

  // Underflow clear request holds until the FIFO reports the flag low
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clear_req <= 1'b0;
    end else if (!underflow_sticky) begin
      clear_req <= 1'b0;
    end else if (status_clear_wr) begin
      clear_req <= 1'b1;
    end
  end

  assign clear_underflow = clear_req && underflow_sticky;

  always_comb begin
    case (av_address)
      REG_STATUS:     read_mux = {12'd0, genlocked, underflow_sticky, 1'b0, enable_resync};
      REG_IRQ:        read_mux = {13'd0, irq_pend, 1'b0};
      REG_USEDW:      read_mux = bus_data_t'(usedw);
      REG_MODE_MATCH: read_mux = bus_data_t'(mode_match_q);
      default:        read_mux = bus_data_t'(ctrl);
    endcase
  end

  assign av_readdata = av_read ? read_mux : '0;

endmodule

`default_nettype wire

// ==== hw/vid_mode_bank.sv ====
// Video mode register bank
// Holds the mode timings, acknowledges bus writes and matches the frame format
`timescale 1ns/100ps
`default_nettype none

module vid_mode_bank
  import vid_bus_pkg::*;
  import vid_video_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  mode_wr_t     mode_wr,
  output logic         wr_ack,
  input  tcount_t      fmt_width,
  input  tcount_t      fmt_height,
  input  logic         fmt_valid,
  output mode_mask_t   mode_match,
  output logic         mode_change,
  output mode_timing_t active_mode
);

  mode_timing_t timings [NUM_MODES];
  mode_mask_t   mode_valid;
  mode_mask_t   fmt_hit;
  bus_addr_t    wr_offset;
  bus_addr_t    wr_mode;
  bus_addr_t    wr_field;
  logic         wr_take;

  // Decode the mode index and field from the bus address
  assign wr_offset = mode_wr.addr - MODE_BASE;
  assign wr_mode   = wr_offset / MODE_STRIDE;
  assign wr_field  = wr_offset % MODE_STRIDE;
  assign wr_take   = mode_wr.valid && !wr_ack && (mode_wr.addr >= MODE_BASE);

  always_ff @(posedge clk) begin
    for (int m = 0; m < NUM_MODES; m++) begin
      if (wr_take && (wr_mode == bus_addr_t'(m))) begin
        case (wr_field)
          F_H_ACTIVE: timings[m].h_active <= tcount_t'(mode_wr.data);
          F_H_TOTAL:  timings[m].h_total  <= tcount_t'(mode_wr.data);
          F_V_ACTIVE: timings[m].v_active <= tcount_t'(mode_wr.data);
          F_V_TOTAL:  timings[m].v_total  <= tcount_t'(mode_wr.data);
          default:    ;
        endcase
      end
    end
  end

  always_comb begin
    fmt_hit = '0;
    for (int m = 0; m < NUM_MODES; m++) begin
      fmt_hit[m] = mode_valid[m] && (timings[m].h_active == fmt_width)
                   && (timings[m].v_active == fmt_height);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ack      <= 1'b0;
      mode_valid  <= '0;
      mode_match  <= '0;
      mode_change <= 1'b0;
    end else begin
      // Every write is acked once, so a held write is not taken twice
      wr_ack <= mode_wr.valid && !wr_ack;
      for (int m = 0; m < NUM_MODES; m++) begin
        if (wr_take && (wr_mode == bus_addr_t'(m)) && (wr_field == F_VALID)) begin
          mode_valid[m] <= mode_wr.data[0];
        end
      end
      mode_change <= fmt_valid && (fmt_hit != mode_match);
      if (fmt_valid) begin
        mode_match <= fmt_hit;
      end
    end
  end

  // Lowest matching mode drives the raster timing
  always_comb begin
    active_mode = '0;
    for (int m = NUM_MODES - 1; m >= 0; m--) begin
      if (mode_match[m]) begin
        active_mode = timings[m];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/vid_pixel_fifo.sv ====
// Pixel FIFO
// Show-ahead circular buffer with fill count and a sticky underflow flag
`timescale 1ns/100ps
`default_nettype none

module vid_pixel_fifo
  import vid_video_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  pixel_t pix_in,
  input  logic   pix_valid,
  output logic   pix_ready,
  input  logic   pop,
  output pixel_t pix_out,
  output usedw_t usedw,
  output logic   underflow_sticky,
  input  logic   clear_underflow
);

  pixel_t                     mem [FIFO_DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  usedw_t                     count;
  logic                       full;
  logic                       empty;
  logic                       push;
  logic                       take;

  assign full      = count == usedw_t'(FIFO_DEPTH);
  assign empty     = count == '0;
  assign pix_ready = !full;
  assign push      = pix_valid && !full;
  assign take      = pop && !empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= pix_in;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // A pop on an empty FIFO outranks a clear in the same cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      underflow_sticky <= 1'b0;
    end else if (pop && empty) begin
      underflow_sticky <= 1'b1;
    end else if (clear_underflow) begin
      underflow_sticky <= 1'b0;
    end
  end

  // Head of the queue, black when nothing is buffered
  assign pix_out = empty ? '0 : mem[rd_ptr];
  assign usedw   = count;

endmodule

`default_nettype wire

// ==== hw/vid_timing_gen.sv ====
// Raster timing generator
// Line and frame counters, sync and data enable, FIFO pops and genlock
`timescale 1ns/100ps
`default_nettype none

module vid_timing_gen
  import vid_bus_pkg::*;
  import vid_video_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  ctrl_reg_t    ctrl,
  input  mode_timing_t timing,
  input  logic         ref_vsync,
  output logic         pop,
  input  pixel_t       pix,
  output vid_out_t     vid,
  output logic         enable_resync,
  output logic         genlocked
);

  gen_state_t state;
  gen_state_t state_next;
  tcount_t    h_count;
  tcount_t    v_count;
  logic       line_end;
  logic       frame_end;
  logic       frame_start;
  logic       active;
  logic       ref_q;
  logic       ref_rise;
  logic [1:0] lock_hits;
  logic       de_q;
  logic       hsync_q;
  logic       vsync_q;
  pixel_t     pix_q;

  assign line_end    = h_count >= timing.h_total - tcount_t'(1);
  assign frame_end   = line_end && (v_count >= timing.v_total - tcount_t'(1));
  assign frame_start = (h_count == '0) && (v_count == '0);
  assign ref_rise    = ref_vsync && !ref_q;

  always_comb begin
    state_next = state;
    case (state)
      IDLE:       if (ctrl.enable) state_next = WAIT_FRAME;
      WAIT_FRAME: begin
        if (!ctrl.enable) begin
          state_next = IDLE;
        end else if (line_end) begin
          state_next = RUN;
        end
      end
      RUN:        if (!ctrl.enable) state_next = IDLE;
      default:    state_next = IDLE;
    endcase
  end

  // A reference edge marks its own cycle as frame start, so the count moves on to 1
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= IDLE;
      h_count <= '0;
      v_count <= '0;
      ref_q   <= 1'b0;
    end else begin
      state <= state_next;
      ref_q <= ref_vsync;
      if (ctrl.genlock_enable[1] && ref_rise) begin
        h_count <= tcount_t'(1);
        v_count <= '0;
      end else if (line_end) begin
        h_count <= '0;
        v_count <= frame_end ? '0 : v_count + tcount_t'(1);
      end else begin
        h_count <= h_count + tcount_t'(1);
      end
    end
  end

  // Lock after two consecutive coincident frame starts, drop on any miss
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lock_hits <= '0;
      genlocked <= 1'b0;
    end else if (!ctrl.genlock_enable[0]) begin
      lock_hits <= '0;
      genlocked <= 1'b0;
    end else if (ref_rise) begin
      if (frame_start) begin
        if (lock_hits != 2'd2) lock_hits <= lock_hits + 2'd1;
        if (lock_hits != 2'd0) genlocked <= 1'b1;
      end else begin
        lock_hits <= '0;
        genlocked <= 1'b0;
      end
    end
  end

  assign active        = (state == RUN) && (h_count < timing.h_active)
                         && (v_count < timing.v_active);
  assign pop           = active;
  assign enable_resync = state == WAIT_FRAME;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      de_q    <= 1'b0;
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
    end else begin
      de_q    <= active;
      hsync_q <= (state == RUN) && (h_count < HSYNC_CYCLES);
      vsync_q <= (state == RUN) && (v_count == '0);
    end
  end

  always_ff @(posedge clk) begin
    pix_q <= active ? pix : '0;
  end

  assign vid = '{de: de_q, hsync: hsync_q, vsync: vsync_q, pixel: pix_q};

endmodule

`default_nettype wire

// ==== hw/vid_out_top.sv ====
// Video output subsystem top
// Control block, mode bank, pixel FIFO and timing generator
`timescale 1ns/100ps
`default_nettype none

module vid_out_top
  import vid_bus_pkg::*;
  import vid_video_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  bus_addr_t av_address,
  input  logic      av_read,
  input  logic      av_write,
  input  bus_data_t av_writedata,
  output bus_data_t av_readdata,
  output logic      av_waitrequest,
  input  pixel_t    pix_in,
  input  logic      pix_valid,
  output logic      pix_ready,
  input  tcount_t   fmt_width,
  input  tcount_t   fmt_height,
  input  logic      fmt_valid,
  input  logic      ref_vsync,
  output vid_out_t  vid,
  output logic      irq
);

  mode_wr_t     mode_wr;
  logic         wr_ack;
  logic         mode_change;
  mode_mask_t   mode_match;
  mode_timing_t active_mode;
  usedw_t       usedw;
  logic         underflow_sticky;
  logic         clear_underflow;
  logic         enable_resync;
  logic         genlocked;
  logic         write_trigger_ack;
  ctrl_reg_t    ctrl;
  logic         pop;
  pixel_t       fifo_pix;

  vid_out_control u_control (
    .clk              (clk),
    .rst              (rst),
    .av_address       (av_address),
    .av_read          (av_read),
    .av_write         (av_write),
    .av_writedata     (av_writedata),
    .av_readdata      (av_readdata),
    .av_waitrequest   (av_waitrequest),
    .mode_wr          (mode_wr),
    .wr_ack           (wr_ack),
    .mode_change      (mode_change),
    .mode_match       (mode_match),
    .usedw            (usedw),
    .underflow_sticky (underflow_sticky),
    .enable_resync    (enable_resync),
    .genlocked        (genlocked),
    .ctrl             (ctrl),
    .clear_underflow  (clear_underflow),
    .write_trigger_ack(write_trigger_ack),
    .irq              (irq)
  );

  vid_mode_bank u_mode_bank (
    .clk        (clk),
    .rst        (rst),
    .mode_wr    (mode_wr),
    .wr_ack     (wr_ack),
    .fmt_width  (fmt_width),
    .fmt_height (fmt_height),
    .fmt_valid  (fmt_valid),
    .mode_match (mode_match),
    .mode_change(mode_change),
    .active_mode(active_mode)
  );

  vid_pixel_fifo u_fifo (
    .clk             (clk),
    .rst             (rst),
    .pix_in          (pix_in),
    .pix_valid       (pix_valid),
    .pix_ready       (pix_ready),
    .pop             (pop),
    .pix_out         (fifo_pix),
    .usedw           (usedw),
    .underflow_sticky(underflow_sticky),
    .clear_underflow (clear_underflow)
  );

  vid_timing_gen u_timing_gen (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .timing       (active_mode),
    .ref_vsync    (ref_vsync),
    .pop          (pop),
    .pix          (fifo_pix),
    .vid          (vid),
    .enable_resync(enable_resync),
    .genlocked    (genlocked)
  );

endmodule

`default_nettype wire

// ==== sim/vid_out_assertions.sv ====
// Bus and sticky-flag checks for the video output control block
// Bound into every vid_out_control instance
`timescale 1ns/100ps
`default_nettype none

module vid_out_assertions
  import vid_bus_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      av_waitrequest,
  input mode_wr_t  mode_wr,
  input logic      wr_ack,
  input logic      write_trigger_ack,
  input ctrl_reg_t ctrl,
  input logic      irq,
  input logic      clear_underflow,
  input logic      underflow_sticky
);

  // Read by the testbench when it sums up the run
  int fail_count = 0;

  // Mode bank write stalls one cycle, then the ack releases it
  mode_write_two_cycles: assert property (@(posedge clk) disable iff (rst)
    (mode_wr.valid && !wr_ack) |=> (wr_ack && !av_waitrequest))
    else begin
      $error("mode bank write did not complete in two cycles");
      fail_count++;
    end

  trigger_ack_delay: assert property (@(posedge clk) disable iff (rst)
    write_trigger_ack == $past(wr_ack))
    else begin
      $error("write_trigger_ack does not follow wr_ack by one cycle");
      fail_count++;
    end

  reset_values: assert property (@(posedge clk)
    (rst && $past(rst)) |-> ((ctrl == '0) && !irq && !clear_underflow
                             && !write_trigger_ack && !av_waitrequest))
    else begin
      $error("control outputs not low during reset");
      fail_count++;
    end

  clear_needs_sticky: assert property (@(posedge clk) disable iff (rst)
    clear_underflow |-> underflow_sticky)
    else begin
      $error("clear_underflow high while the underflow flag is low");
      fail_count++;
    end

endmodule

bind vid_out_control vid_out_assertions u_assertions (
  .clk              (clk),
  .rst              (rst),
  .av_waitrequest   (av_waitrequest),
  .mode_wr          (mode_wr),
  .wr_ack           (wr_ack),
  .write_trigger_ack(write_trigger_ack),
  .ctrl             (ctrl),
  .irq              (irq),
  .clear_underflow  (clear_underflow),
  .underflow_sticky (underflow_sticky)
);

`default_nettype wire

// ==== sim/vid_out_tb.sv ====
// Testbench for the video output subsystem
// Directed register, mode bank, interrupt, video, underflow and genlock tests
`timescale 1ns/100ps
`default_nettype none

module vid_out_tb
  import vid_bus_pkg::*;
  import vid_video_pkg::*;
();

  // Mode 0 drives the raster, mode 1 only takes part in format matching
  localparam int M0_H_ACTIVE = 8;
  localparam int M0_H_TOTAL  = 24;
  localparam int M0_V_ACTIVE = 3;
  localparam int M0_V_TOTAL  = 5;
  localparam int M1_H_ACTIVE = 16;
  localparam int M1_H_TOTAL  = 40;
  localparam int M1_V_ACTIVE = 4;
  localparam int M1_V_TOTAL  = 6;

  localparam int FRAME_CYCLES   = M0_H_TOTAL * M0_V_TOTAL;
  // Three short bus tests, two frames each for video and underflow, six for genlock
  localparam int TEST_CYCLES    = 3 * 50 + 4 * FRAME_CYCLES + 6 * FRAME_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic      clk;
  logic      rst;
  bus_addr_t av_address;
  logic      av_read;
  logic      av_write;
  bus_data_t av_writedata;
  bus_data_t av_readdata;
  logic      av_waitrequest;
  pixel_t    pix_in;
  logic      pix_valid;
  logic      pix_ready;
  tcount_t   fmt_width;
  tcount_t   fmt_height;
  logic      fmt_valid;
  logic      ref_vsync;
  vid_out_t  vid;
  logic      irq;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          assert_fails;
  int          cycle_count;
  logic [31:0] lfsr_state;
  pixel_t      expected_pixels[$];

  vid_out_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .av_address    (av_address),
    .av_read       (av_read),
    .av_write      (av_write),
    .av_writedata  (av_writedata),
    .av_readdata   (av_readdata),
    .av_waitrequest(av_waitrequest),
    .pix_in        (pix_in),
    .pix_valid     (pix_valid),
    .pix_ready     (pix_ready),
    .fmt_width     (fmt_width),
    .fmt_height    (fmt_height),
    .fmt_valid     (fmt_valid),
    .ref_vsync     (ref_vsync),
    .vid           (vid),
    .irq           (irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    lfsr_step = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  task automatic next_pixel(output pixel_t p);
    for (int i = 0; i < $bits(pixel_t); i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      p[i]       = lfsr_state[0];
    end
  endtask

  // All stimulus changes 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) tick();
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error in %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d error(s)", name, errors - start);
    end
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data, output int waits);
    logic busy;
    waits        = 0;
    av_address   = addr;
    av_writedata = data;
    av_write     = 1'b1;
    busy         = 1'b1;
    while (busy) begin
      #2;
      busy = av_waitrequest;
      if (busy) waits++;
      tick();
    end
    av_write = 1'b0;
  endtask

  task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
    int waits;
    bus_write(addr, data, waits);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
    logic busy;
    av_address = addr;
    av_read    = 1'b1;
    busy       = 1'b1;
    while (busy) begin
      #2;
      busy = av_waitrequest;
      data = av_readdata;
      tick();
    end
    av_read = 1'b0;
  endtask

  function automatic bus_addr_t mode_addr(input int mode, input bus_addr_t field);
    mode_addr = MODE_BASE + bus_addr_t'(mode) * MODE_STRIDE + field;
  endfunction

  // A mode matches when both of its active sizes equal the format
  function automatic mode_mask_t expected_mask(input int w, input int h);
    expected_mask[0] = (w == M0_H_ACTIVE) && (h == M0_V_ACTIVE);
    expected_mask[1] = (w == M1_H_ACTIVE) && (h == M1_V_ACTIVE);
  endfunction

  task automatic mode_field_write(input int mode, input bus_addr_t field, input int value);
    int waits;
    bus_write(mode_addr(mode, field), bus_data_t'(value), waits);
    check_equal("mode_programming", 1, waits);
  endtask

  task automatic program_mode(input int mode, input int ha, input int ht,
                              input int va, input int vt);
    mode_field_write(mode, F_H_ACTIVE, ha);
    mode_field_write(mode, F_H_TOTAL, ht);
    mode_field_write(mode, F_V_ACTIVE, va);
    mode_field_write(mode, F_V_TOTAL, vt);
    mode_field_write(mode, F_VALID, 1);
  endtask

  // Match is latched after one cycle, the control copy one cycle later
  task automatic send_format(input int w, input int h);
    fmt_width  = tcount_t'(w);
    fmt_height = tcount_t'(h);
    fmt_valid  = 1'b1;
    tick();
    fmt_valid = 1'b0;
    wait_cycles(2);
  endtask

  task automatic push_pixels(input int n);
    pixel_t p;
    logic   accepted;
    for (int i = 0; i < n; i++) begin
      next_pixel(p);
      pix_in    = p;
      pix_valid = 1'b1;
      accepted  = 1'b0;
      while (!accepted) begin
        #2;
        accepted = pix_ready;
        tick();
      end
      expected_pixels.push_back(p);
    end
    pix_valid = 1'b0;
  endtask

  task automatic ctrl_readback();
    int        start;
    bus_data_t rd;
    start = errors;
    write_reg(REG_CTRL, 16'hFFF6);
    bus_read(REG_CTRL, rd);
    check_equal("ctrl_readback", 16'h0016, rd);
    write_reg(REG_CTRL, 16'h000E);
    bus_read(REG_CTRL, rd);
    check_equal("ctrl_readback", 16'h000E, rd);
    // Addresses outside the register map fall back to the control word
    bus_read(8'h07, rd);
    check_equal("ctrl_readback", 16'h000E, rd);
    bus_read(8'h40, rd);
    check_equal("ctrl_readback", 16'h000E, rd);
    write_reg(REG_CTRL, 16'h0000);
    finish_test("ctrl_readback", start);
  endtask

  task automatic mode_programming();
    int        start;
    bus_data_t rd;
    start = errors;
    program_mode(0, M0_H_ACTIVE, M0_H_TOTAL, M0_V_ACTIVE, M0_V_TOTAL);
    program_mode(1, M1_H_ACTIVE, M1_H_TOTAL, M1_V_ACTIVE, M1_V_TOTAL);
    send_format(M0_H_ACTIVE, M0_V_ACTIVE);
    bus_read(REG_MODE_MATCH, rd);
    check_equal("mode_programming", expected_mask(M0_H_ACTIVE, M0_V_ACTIVE), rd);
    finish_test("mode_programming", start);
  endtask

  task automatic mode_irq();
    int        start;
    bus_data_t rd;
    start = errors;
    write_reg(REG_CTRL, 16'h0002);
    send_format(M1_H_ACTIVE, M1_V_ACTIVE);
    check_equal("mode_irq", 1, irq);
    bus_read(REG_IRQ, rd);
    check_equal("mode_irq", 1, rd[1]);
    write_reg(REG_IRQ, 16'h0002);
    check_equal("mode_irq", 0, irq);
    bus_read(REG_IRQ, rd);
    check_equal("mode_irq", 0, rd[1]);
    // Interrupt disabled, so the change back to mode 0 stays silent
    write_reg(REG_CTRL, 16'h0000);
    send_format(M0_H_ACTIVE, M0_V_ACTIVE);
    check_equal("mode_irq", 0, irq);
    bus_read(REG_IRQ, rd);
    check_equal("mode_irq", 0, rd);
    bus_read(REG_MODE_MATCH, rd);
    check_equal("mode_irq", expected_mask(M0_H_ACTIVE, M0_V_ACTIVE), rd);
    finish_test("mode_irq", start);
  endtask

  task automatic video_output();
    int        start;
    int        run;
    int        lines;
    int        popped;
    logic      line_vsync;
    bus_data_t used_before;
    bus_data_t rd;
    pixel_t    want;
    start = errors;
    push_pixels(FIFO_DEPTH);
    // A full FIFO drops ready
    check_equal("video_output", 0, pix_ready);
    bus_read(REG_USEDW, used_before);
    check_equal("video_output", FIFO_DEPTH, used_before);
    write_reg(REG_CTRL, 16'h0001);
    run        = 0;
    lines      = 0;
    popped     = 0;
    line_vsync = 1'b0;
    while (lines < 2) begin
      tick();
      if (vid.de) begin
        want = '0;
        assert (expected_pixels.size() > 0) else begin
          $display("video_output: more pixels came out than were written to the FIFO");
          errors++;
        end
        if (expected_pixels.size() > 0) want = expected_pixels.pop_front();
        check_equal("video_output", want, vid.pixel);
        // Active pixels sit inside the 8-cycle hsync pulse at the line start
        check_equal("video_output", 1, vid.hsync);
        if (run == 0) begin
          line_vsync = vid.vsync;
        end else begin
          check_equal("video_output", line_vsync, vid.vsync);
        end
        run++;
        popped++;
      end else if (run != 0) begin
        check_equal("video_output", M0_H_ACTIVE, run);
        check_equal("video_output", 0, vid.hsync);
        // Only the first line of a frame carries vsync
        if (lines == 1) check_equal("video_output", 0, line_vsync);
        lines++;
        run = 0;
      end
    end
    // Stop in the horizontal blanking, before the next line pops again
    write_reg(REG_CTRL, 16'h0000);
    bus_read(REG_USEDW, rd);
    check_equal("video_output", used_before - popped, rd);
    finish_test("video_output", start);
  endtask

  task automatic underflow_recovery();
    int        start;
    bus_data_t rd;
    start = errors;
    bus_read(REG_USEDW, rd);
    check_equal("underflow_recovery", 0, rd);
    bus_read(REG_STATUS, rd);
    check_equal("underflow_recovery", 0, rd[2]);
    write_reg(REG_CTRL, 16'h0001);
    while (!rd[2]) begin
      bus_read(REG_STATUS, rd);
    end
    write_reg(REG_CTRL, 16'h0000);
    wait_cycles(2);
    bus_read(REG_STATUS, rd);
    check_equal("underflow_recovery", 1, rd[2]);
    write_reg(REG_STATUS, 16'h0004);
    wait_cycles(3);
    bus_read(REG_STATUS, rd);
    check_equal("underflow_recovery", 0, rd[2]);
    finish_test("underflow_recovery", start);
  endtask

  task automatic genlock_lock();
    int        start;
    int        pulses;
    bus_data_t rd;
    start  = errors;
    pulses = 0;
    rd     = '0;
    // Both genlock enables plus the genlock interrupt
    write_reg(REG_CTRL, 16'h001C);
    while (!rd[3] && (pulses < 6)) begin
      ref_vsync = 1'b1;
      tick();
      ref_vsync = 1'b0;
      bus_read(REG_STATUS, rd);
      wait_cycles(FRAME_CYCLES - 2);
      pulses++;
    end
    check_equal("genlock_lock", 1, rd[3]);
    bus_read(REG_IRQ, rd);
    check_equal("genlock_lock", 1, rd[2]);
    check_equal("genlock_lock", 1, irq);
    write_reg(REG_IRQ, 16'h0004);
    check_equal("genlock_lock", 0, irq);
    write_reg(REG_CTRL, 16'h0000);
    finish_test("genlock_lock", start);
  endtask

  initial begin
    rst          = 1'b1;
    av_address   = '0;
    av_read      = 1'b0;
    av_write     = 1'b0;
    av_writedata = '0;
    pix_in       = '0;
    pix_valid    = 1'b0;
    fmt_width    = '0;
    fmt_height   = '0;
    fmt_valid    = 1'b0;
    ref_vsync    = 1'b0;
    lfsr_state   = 32'd99418;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    tick();
    ctrl_readback();
    mode_programming();
    mode_irq();
    video_output();
    underflow_recovery();
    genlock_lock();
    assert_fails = u_dut.u_control.u_assertions.fail_count;
    $display("Tests run %0d, with errors %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vid_out.f ====
hw/vid_bus_pkg.sv
hw/vid_video_pkg.sv
hw/vid_out_control.sv
hw/vid_mode_bank.sv
hw/vid_pixel_fifo.sv
hw/vid_timing_gen.sv
hw/vid_out_top.sv
sim/vid_out_assertions.sv
sim/vid_out_tb.sv

// ==== Bender.yml ====
package:
  name: vid_out

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - hw/vid_bus_pkg.sv
      - hw/vid_video_pkg.sv
      - hw/vid_out_control.sv
      - hw/vid_mode_bank.sv
      - hw/vid_pixel_fifo.sv
      - hw/vid_timing_gen.sv
      - hw/vid_out_top.sv
  - target: simulation
    files:
      - sim/vid_out_assertions.sv
      - sim/vid_out_tb.sv
